/* lsab_dram_top.f */
+incdir+include
rtl/lsab_pkg.sv
rtl/section_buffers.sv
rtl/page_aligner.sv
rtl/block_mover.sv
rtl/block_sequencer.sv
rtl/lsab_dram_top.sv
sim/page_ctrl_model.sv
sim/tb_lsab_dram.sv

/* Makefile */
# Verilator build and run of the DRAM block-store testbench

TOP := tb_lsab_dram

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal \
	  -f lsab_dram_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* sim/tb_lsab_dram.sv */
`timescale 1ns/100ps
`include "lsab_settings.svh"

module tb_lsab_dram;
  import lsab_pkg::*;

  localparam int wait_limit = 1000;

  logic CLK;
  logic RST;
  logic go;
  dram_addr_u new_addr;
  len_t block_length;
  section_t new_section;
  logic buf_wr_en;
  section_t buf_wr_section;
  len_t buf_wr_index;
  word_t buf_wr_data;
  logic page_ack;
  logic ready;
  dram_addr_u old_addr;
  logic page_req;
  page_t page_out;
  logic dram_wr_en;
  logic [`LSAB_ADDR_W-1:0] dram_wr_addr;
  word_t dram_wr_data;

  // host copy of the section buffers and a record of every DRAM write
  word_t shadow_buf [0:3][0:`LSAB_BUF_DEPTH-1];
  word_t shadow_dram [logic [`LSAB_ADDR_W-1:0]];
  int write_count = 0;
  int req_rises = 0;
  page_t req_page = '0;
  page_t open_page = '0;
  logic open_valid = 1'b0;
  logic req_prev = 1'b0;
  logic ack_prev = 1'b0;
  page_t out_prev = '0;
  page_t last_page = '0;
  logic last_valid = 1'b0;

  lsab_dram_top UUT (.*);

  page_ctrl_model u_page_ctrl (
    .CLK      (CLK),
    .RST      (RST),
    .page_req (page_req),
    .page_ack (page_ack)
  );

  always #50 CLK = ~CLK;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // a block stops at the end of its page
  function automatic int expected_count(input offset_t offset, input len_t len);
    int off;
    off = int'(offset);
    if (off + int'(len) <= 4096)
      return int'(len);
    return 4096 - off;
  endfunction

  task automatic fill_section(input section_t sec);
    word_t data;
    int i;
    for (i = 0; i < `LSAB_BUF_DEPTH; i++)
    begin
      data = word_t'($urandom);
      shadow_buf[sec][i] = data;
      @(posedge CLK);
      buf_wr_en <= 1'b1;
      buf_wr_section <= sec;
      buf_wr_index <= len_t'(i);
      buf_wr_data <= data;
    end
    @(posedge CLK);
    buf_wr_en <= 1'b0;
  endtask

  task automatic run_command(input page_t page, input offset_t offset, input len_t len,
                             input section_t sec, input bit busy_go);
    dram_addr_u cmd;
    dram_addr_u exp_next;
    logic [`LSAB_ADDR_W-1:0] a;
    int cnt;
    int writes_before;
    int rises_before;
    int exp_rises;
    int waited;
    int i;
    cmd.fields.page = page;
    cmd.fields.offset = offset;
    cnt = expected_count(offset, len);
    exp_next.flat = cmd.flat + 32'(cnt);
    // only a page other than the one left open needs a handshake
    exp_rises = (last_valid && page == last_page) ? 0 : 1;
    writes_before = write_count;
    rises_before = req_rises;
    shadow_dram.delete();
    @(posedge CLK);
    go <= 1'b1;
    new_addr <= cmd;
    block_length <= len;
    new_section <= sec;
    @(posedge CLK);
    go <= 1'b0;
    if (busy_go)
    begin
      @(posedge CLK);
      go <= 1'b1;
      new_addr.flat <= ~cmd.flat;
      block_length <= 6'd5;
      @(posedge CLK);
      go <= 1'b0;
    end
    waited = 0;
    do
    begin
      @(negedge CLK);
      waited++;
      assert (waited < wait_limit) else abort_run("timeout waiting for ready after a command");
    end
    while (!ready);
    assert (old_addr.flat == exp_next.flat)
      else report_mismatch("old_addr", old_addr.flat, exp_next.flat);
    @(posedge CLK);
    assert (write_count - writes_before == cnt)
      else report_mismatch("dram_wr_en count", 32'(write_count - writes_before), 32'(cnt));
    assert (req_rises - rises_before == exp_rises)
      else report_mismatch("page_req pulses", 32'(req_rises - rises_before), 32'(exp_rises));
    if (exp_rises == 1)
      assert (req_page == page) else report_mismatch("page_out", 32'(req_page), 32'(page));
    for (i = 0; i < cnt; i++)
    begin
      a = cmd.flat + 32'(i);
      assert (shadow_dram.exists(a))
        else abort_run($sformatf("no DRAM write seen at address 0x%08h", a));
      assert (shadow_dram[a] == shadow_buf[sec][i])
        else report_mismatch("dram_wr_data", 32'(shadow_dram[a]), 32'(shadow_buf[sec][i]));
    end
    last_page = page;
    last_valid = 1'b1;
  endtask

  // the four-phase rules and the DRAM write record are sampled away from the clock edge
  always @(negedge CLK)
  begin
    if (RST)
    begin
      if (page_req && !req_prev)
      begin
        assert (!ack_prev) else abort_run("page_req rose while page_ack was still high");
        req_rises = req_rises + 1;
        req_page = page_out;
        open_valid = 1'b0;
      end
      if (!page_req && req_prev)
        assert (ack_prev) else abort_run("page_req fell before page_ack was high");
      if (page_req && req_prev)
        assert (page_out == out_prev)
          else report_mismatch("page_out", 32'(page_out), 32'(out_prev));
      if (!page_ack && ack_prev)
      begin
        open_page = page_out;
        open_valid = 1'b1;
      end
      if (dram_wr_en)
      begin
        assert (open_valid && dram_wr_addr[31:12] == open_page)
          else abort_run($sformatf("DRAM write to 0x%08h outside the open page", dram_wr_addr));
        shadow_dram[dram_wr_addr] = dram_wr_data;
        write_count = write_count + 1;
      end
    end
    req_prev = page_req;
    ack_prev = page_ack;
    out_prev = page_out;
  end

  initial
  begin
    int n;
    page_t pg;
    offset_t off;
    void'($urandom(32'hf9cf));
    CLK = 1'b0;
    RST = 1'b0;
    go = 1'b0;
    new_addr = '0;
    block_length = '0;
    new_section = '0;
    buf_wr_en = 1'b0;
    buf_wr_section = '0;
    buf_wr_index = '0;
    buf_wr_data = '0;
    repeat (5) @(posedge CLK);
    RST <= 1'b1;
    @(negedge CLK);
    assert (ready === 1'b1) else report_mismatch("ready", 32'(ready), 32'h1);
    assert (page_req === 1'b0) else report_mismatch("page_req", 32'(page_req), 32'h0);
    assert (dram_wr_en === 1'b0) else report_mismatch("dram_wr_en", 32'(dram_wr_en), 32'h0);
    for (n = 0; n < 4; n++)
      fill_section(section_t'(n));
    // a new page is followed by the same page without a handshake
    run_command(20'h12345, 12'h100, 6'd17, 2'd1, 1'b0);
    run_command(20'h12345, 12'h200, 6'd63, 2'd2, 1'b0);
    // a block clipped at the page end is followed by exact fits that see a go while busy
    run_command(20'h0abcd, 12'hff0, 6'd40, 2'd3, 1'b0);
    run_command(20'h0abcd, 12'hfc1, 6'd63, 2'd0, 1'b1);
    run_command(20'h0abcd, 12'hfff, 6'd1, 2'd2, 1'b1);
    for (n = 0; n < 40; n++)
    begin
      if (n % 10 == 9)
        fill_section(section_t'($urandom % 4));
      pg = 20'h40000 + page_t'($urandom % 3);
      if ($urandom % 4 == 0)
        off = offset_t'(12'hfff - 12'($urandom % 64));
      else
        off = offset_t'($urandom);
      run_command(pg, off, len_t'(1 + $urandom % 63), section_t'($urandom % 4),
                  ($urandom % 8 == 0));
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

/* sim/page_ctrl_model.sv */
`timescale 1ns/100ps

module page_ctrl_model (
  input  logic CLK,
  input  logic RST,
  input  logic page_req,
  output logic page_ack
);

  logic [2:0] delay;

  // a phase is pending while the request and the acknowledge disagree
  always @(posedge CLK)
  begin
    if (!RST)
    begin
      page_ack <= 1'b0;
      delay <= 3'($urandom % 8);
    end
    else if (page_req != page_ack)
    begin
      if (delay == 3'd0)
      begin
        page_ack <= page_req;
        delay <= 3'($urandom % 8);
      end
      else
        delay <= delay - 3'd1;
    end
  end

endmodule

/* rtl/lsab_dram_top.sv */
`timescale 1ns/100ps
`include "lsab_settings.svh"

module lsab_dram_top (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    go,
  input  lsab_pkg::dram_addr_u    new_addr,
  input  lsab_pkg::len_t          block_length,
  input  lsab_pkg::section_t      new_section,
  input  logic                    buf_wr_en,
  input  lsab_pkg::section_t      buf_wr_section,
  input  lsab_pkg::len_t          buf_wr_index,
  input  lsab_pkg::word_t         buf_wr_data,
  input  logic                    page_ack,
  output logic                    ready,
  output lsab_pkg::dram_addr_u    old_addr,
  output logic                    page_req,
  output lsab_pkg::page_t         page_out,
  output logic                    dram_wr_en,
  output logic [`LSAB_ADDR_W-1:0] dram_wr_addr,
  output lsab_pkg::word_t         dram_wr_data
);
  import lsab_pkg::*;

  logic align_req;
  logic align_grant;
  page_t page_addr;
  logic blk_issue;
  page_t blk_page;
  offset_t blk_offset;
  len_t blk_count;
  section_t blk_section;
  logic blk_working;
  len_t blk_sent;
  section_t rd_section;
  len_t rd_index;
  word_t rd_data;

  block_sequencer u_sequencer (
    .CLK          (CLK),
    .RST          (RST),
    .go           (go),
    .new_addr     (new_addr),
    .block_length (block_length),
    .new_section  (new_section),
    .align_grant  (align_grant),
    .blk_working  (blk_working),
    .blk_sent     (blk_sent),
    .ready        (ready),
    .old_addr     (old_addr),
    .align_req    (align_req),
    .page_addr    (page_addr),
    .blk_issue    (blk_issue),
    .blk_page     (blk_page),
    .blk_offset   (blk_offset),
    .blk_count    (blk_count),
    .blk_section  (blk_section)
  );

  page_aligner u_aligner (
    .CLK         (CLK),
    .RST         (RST),
    .align_req   (align_req),
    .page_addr   (page_addr),
    .page_ack    (page_ack),
    .align_grant (align_grant),
    .page_req    (page_req),
    .page_out    (page_out)
  );

  block_mover u_mover (
    .CLK          (CLK),
    .RST          (RST),
    .blk_issue    (blk_issue),
    .blk_page     (blk_page),
    .blk_offset   (blk_offset),
    .blk_count    (blk_count),
    .blk_section  (blk_section),
    .rd_data      (rd_data),
    .blk_working  (blk_working),
    .blk_sent     (blk_sent),
    .rd_section   (rd_section),
    .rd_index     (rd_index),
    .dram_wr_en   (dram_wr_en),
    .dram_wr_addr (dram_wr_addr),
    .dram_wr_data (dram_wr_data)
  );

  section_buffers u_buffers (
    .CLK            (CLK),
    .buf_wr_en      (buf_wr_en),
    .buf_wr_section (buf_wr_section),
    .buf_wr_index   (buf_wr_index),
    .buf_wr_data    (buf_wr_data),
    .rd_section     (rd_section),
    .rd_index       (rd_index),
    .rd_data        (rd_data)
  );

endmodule

/* rtl/block_sequencer.sv */
`timescale 1ns/100ps
`include "lsab_settings.svh"

module block_sequencer (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 go,
  input  lsab_pkg::dram_addr_u new_addr,
  input  lsab_pkg::len_t       block_length,
  input  lsab_pkg::section_t   new_section,
  input  logic                 align_grant,
  input  logic                 blk_working,
  input  lsab_pkg::len_t       blk_sent,
  output logic                 ready,
  output lsab_pkg::dram_addr_u old_addr,
  output logic                 align_req,
  output lsab_pkg::page_t      page_addr,
  output logic                 blk_issue,
  output lsab_pkg::page_t      blk_page,
  output lsab_pkg::offset_t    blk_offset,
  output lsab_pkg::len_t       blk_count,
  output lsab_pkg::section_t   blk_section
);
  import lsab_pkg::*;

  // number of words in one DRAM page
  localparam logic [`LSAB_OFFSET_W:0] page_span = {1'b1, {`LSAB_OFFSET_W{1'b0}}};

  seq_state_t state;
  dram_addr_u cmd_addr;
  len_t cmd_len;
  section_t cmd_section;
  logic working_prev;
  logic issued;
  logic do_go;
  logic retire;
  logic issue_ok;
  logic [`LSAB_OFFSET_W:0] end_sum;
  logic [`LSAB_OFFSET_W:0] room;

  assign ready = (state == seq_idle);
  assign do_go = go && ready;

  // the move is over once working has been seen high and then low
  assign retire = (state == seq_move) && working_prev && !blk_working;

  // one block per command, and only while the mover is fully quiet
  assign issue_ok = align_req && align_grant && !blk_working && !working_prev &&
                    !issued && ((state == seq_size) || (state == seq_move));

  // end of the block relative to the page start, one bit wider than an offset
  assign end_sum = {1'b0, blk_offset} +
                   {{(`LSAB_OFFSET_W + 1 - `LSAB_LEN_W){1'b0}}, cmd_len};
  assign room = page_span - {1'b0, blk_offset};

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state <= seq_idle;
      align_req <= 1'b0;
      blk_issue <= 1'b0;
      issued <= 1'b0;
      working_prev <= 1'b0;
      old_addr <= '0;
    end
    else
    begin
      working_prev <= blk_working;
      blk_issue <= issue_ok;
      if (issue_ok)
        issued <= 1'b1;

      case (state)
        seq_idle:
        begin
          if (do_go)
          begin
            state <= seq_latch;
            align_req <= 1'b1;
            issued <= 1'b0;
          end
        end
        seq_latch:
          state <= seq_size;
        seq_size:
          state <= seq_move;
        seq_move:
        begin
          if (retire)
          begin
            state <= seq_idle;
            align_req <= 1'b0;
            // return address points just past the last word written
            old_addr.flat <= cmd_addr.flat + `LSAB_ADDR_W'(blk_sent);
          end
        end
        default:
          state <= seq_idle;
      endcase
    end
  end

  // command and block fields
  always_ff @(posedge CLK)
  begin
    if (do_go)
    begin
      cmd_addr <= new_addr;
      cmd_len <= block_length;
      cmd_section <= new_section;
      page_addr <= new_addr.fields.page;
    end

    if (state == seq_latch)
    begin
      blk_page <= cmd_addr.fields.page;
      blk_offset <= cmd_addr.fields.offset;
      blk_section <= cmd_section;
    end

    // clip the block at the end of the page
    if (state == seq_size)
    begin
      if (end_sum > page_span)
        blk_count <= room[`LSAB_LEN_W-1:0];
      else
        blk_count <= cmd_len;
    end
  end

endmodule

/* rtl/block_mover.sv */
`timescale 1ns/100ps
`include "lsab_settings.svh"

module block_mover (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    blk_issue,
  input  lsab_pkg::page_t         blk_page,
  input  lsab_pkg::offset_t       blk_offset,
  input  lsab_pkg::len_t          blk_count,
  input  lsab_pkg::section_t      blk_section,
  input  lsab_pkg::word_t         rd_data,
  output logic                    blk_working,
  output lsab_pkg::len_t          blk_sent,
  output lsab_pkg::section_t      rd_section,
  output lsab_pkg::len_t          rd_index,
  output logic                    dram_wr_en,
  output logic [`LSAB_ADDR_W-1:0] dram_wr_addr,
  output lsab_pkg::word_t         dram_wr_data
);
  import lsab_pkg::*;

  page_t cur_page;
  offset_t cur_offset;
  len_t cur_count;
  logic rd_active;
  logic wr_valid;
  len_t wr_count;

  // a read started in one cycle returns its word in the next, where it is written
  assign blk_working = rd_active || wr_valid;
  assign blk_sent = wr_count;

  assign dram_wr_en = wr_valid;
  assign dram_wr_data = rd_data;
  assign dram_wr_addr = {cur_page, cur_offset + offset_t'(wr_count)};

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      rd_active <= 1'b0;
      wr_valid <= 1'b0;
      rd_index <= '0;
      wr_count <= '0;
    end
    else if (blk_issue)
    begin
      rd_active <= 1'b1;
      wr_valid <= 1'b0;
      rd_index <= '0;
      wr_count <= '0;
    end
    else
    begin
      wr_valid <= rd_active;
      if (rd_active)
      begin
        rd_index <= rd_index + 1'b1;
        if (rd_index == cur_count - len_t'(1))
          rd_active <= 1'b0;
      end
      if (wr_valid)
        wr_count <= wr_count + 1'b1;
    end
  end

  // block fields are held for the whole move
  always_ff @(posedge CLK)
  begin
    if (blk_issue)
    begin
      cur_page <= blk_page;
      cur_offset <= blk_offset;
      cur_count <= blk_count;
      rd_section <= blk_section;
    end
  end

endmodule

/* rtl/page_aligner.sv */
`timescale 1ns/100ps

module page_aligner (
  input  logic            CLK,
  input  logic            RST,
  input  logic            align_req,
  input  lsab_pkg::page_t page_addr,
  input  logic            page_ack,
  output logic            align_grant,
  output logic            page_req,
  output lsab_pkg::page_t page_out
);
  import lsab_pkg::*;

  localparam logic [1:0] al_idle = 2'd0;
  localparam logic [1:0] al_wait_ack = 2'd1;
  localparam logic [1:0] al_wait_rel = 2'd2;
  localparam logic [1:0] al_grant = 2'd3;

  logic [1:0] state;
  page_t open_page;
  logic open_valid;
  logic page_hit;

  assign page_hit = open_valid && (open_page == page_addr);

  assign align_grant = (state == al_grant);
  assign page_req = (state == al_wait_ack);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state <= al_idle;
      open_valid <= 1'b0;
    end
    else
    begin
      case (state)
        al_idle:
        begin
          if (align_req)
          begin
            if (page_hit)
              state <= al_grant;
            // a new request waits until the previous ack has been released
            else if (!page_ack)
            begin
              state <= al_wait_ack;
              open_valid <= 1'b0;
            end
          end
        end
        al_wait_ack:
        begin
          if (page_ack)
            state <= al_wait_rel;
        end
        al_wait_rel:
        begin
          if (!page_ack)
          begin
            state <= al_grant;
            open_valid <= 1'b1;
          end
        end
        al_grant:
        begin
          if (!align_req)
            state <= al_idle;
        end
        default:
          state <= al_idle;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if ((state == al_idle) && align_req && !page_hit && !page_ack)
      page_out <= page_addr;
    if ((state == al_wait_rel) && !page_ack)
      open_page <= page_out;
  end

endmodule

/* rtl/section_buffers.sv */
`timescale 1ns/100ps
`include "lsab_settings.svh"

module section_buffers (
  input  logic               CLK,
  input  logic               buf_wr_en,
  input  lsab_pkg::section_t buf_wr_section,
  input  lsab_pkg::len_t     buf_wr_index,
  input  lsab_pkg::word_t    buf_wr_data,
  input  lsab_pkg::section_t rd_section,
  input  lsab_pkg::len_t     rd_index,
  output lsab_pkg::word_t    rd_data
);
  import lsab_pkg::*;

  localparam int unsigned num_sections = 1 << `LSAB_SECTION_W;

  // one row per section, the host fills a section before it names it in a command
  word_t mem [0:num_sections-1][0:`LSAB_BUF_DEPTH-1];

  always_ff @(posedge CLK)
  begin
    if (buf_wr_en)
      mem[buf_wr_section][buf_wr_index] <= buf_wr_data;
  end

  // registered read, the word appears one cycle after its index
  always_ff @(posedge CLK)
  begin
    rd_data <= mem[rd_section][rd_index];
  end

endmodule

/* rtl/lsab_pkg.sv */
`include "lsab_settings.svh"

package lsab_pkg;

  typedef logic [`LSAB_PAGE_W-1:0] page_t;
  typedef logic [`LSAB_OFFSET_W-1:0] offset_t;
  typedef logic [`LSAB_LEN_W-1:0] len_t;
  typedef logic [`LSAB_SECTION_W-1:0] section_t;
  typedef logic [`LSAB_DATA_W-1:0] word_t;

  // a DRAM address is handled both as one flat word and as page plus offset
  typedef union packed {
    logic [`LSAB_ADDR_W-1:0] flat;
    struct packed {
      page_t   page;
      offset_t offset;
    } fields;
  } dram_addr_u;

  // command sequencer states
  typedef enum logic [1:0] {
    seq_idle,
    seq_latch,
    seq_size,
    seq_move
  } seq_state_t;

endpackage

/* include/lsab_settings.svh */
`ifndef LSAB_SETTINGS_SVH
`define LSAB_SETTINGS_SVH

// DRAM word address, split into page and in-page offset
`define LSAB_ADDR_W 32
`define LSAB_PAGE_W 20
`define LSAB_OFFSET_W 12

// block length and word counters, a block holds 1 to 63 words
`define LSAB_LEN_W 6

// four section buffers on the host side
`define LSAB_SECTION_W 2

`define LSAB_DATA_W 16

// words per section buffer
`define LSAB_BUF_DEPTH 64

`endif
